/* common/rv32m_pkg.sv */
// shared RV32M types; op codes equal funct3, sign modes only cover the three RV32M operand readings
`default_nettype none

package rv32m_pkg;

  localparam int WORD_SIZE = 32;
  localparam int CNT_W     = $clog2(WORD_SIZE);  // engine bit counter width

  typedef logic [WORD_SIZE-1:0] word_t;

  // most negative word, used for the signed overflow answer
  localparam word_t WORD_MIN = {1'b1, {(WORD_SIZE-1){1'b0}}};

  typedef enum logic [2:0] {
    OP_MUL    = 3'b000,
    OP_MULH   = 3'b001,
    OP_MULHSU = 3'b010,
    OP_MULHU  = 3'b011,
    OP_DIV    = 3'b100,
    OP_DIVU   = 3'b101,
    OP_REM    = 3'b110,
    OP_REMU   = 3'b111
  } m_op_e;

  // upper bit is rs1 signed, lower bit rs2 signed
  typedef enum logic [1:0] {
    SIGN_UU = 2'b00,
    SIGN_SU = 2'b10,
    SIGN_SS = 2'b11
  } sign_mode_e;

  typedef struct packed {
    logic  valid;
    m_op_e op;
    word_t rs1_data;
    word_t rs2_data;
  } m_req_t;

  typedef struct packed {
    logic  busy;
    logic  done;   // one cycle pulse
    word_t wdata;
  } m_rsp_t;

  typedef struct packed {
    logic       start;
    logic       mul;
    logic       div;
    logic       rem;
    sign_mode_e sign;
    logic       lower_word;  // MUL only
    word_t      op_a;
    word_t      op_b;
  } decode_execute_t;

  typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_e;
  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_e;

endpackage

`default_nettype wire

/* multiplier/shift_add_multiplier.sv */
// operands are sampled only on start; a start while running is ignored, product valid while finished
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                start,
  input  rv32m_pkg::word_t                    multiplicand,
  input  rv32m_pkg::word_t                    multiplier,
  input  rv32m_pkg::sign_mode_e               is_signed,
  output logic [2*rv32m_pkg::WORD_SIZE-1:0]   product,
  output logic                                finished
);

  import rv32m_pkg::*;

  mul_state_e             state_q;
  logic [CNT_W-1:0]       count_q;
  logic                   load;
  logic                   last;
  logic                   a_neg, b_neg;
  word_t                  a_mag, b_mag;
  word_t                  mcand_q;
  logic                   neg_q;
  logic [WORD_SIZE:0]     sum;
  logic [2*WORD_SIZE-1:0] prod_q;
  logic [2*WORD_SIZE-1:0] prod_next;

  assign load = start && (state_q != MUL_RUN);
  assign last = (state_q == MUL_RUN) && (count_q == '0);

  // magnitudes of the signed operands
  assign a_neg = (is_signed != SIGN_UU) & multiplicand[WORD_SIZE-1];
  assign b_neg = (is_signed == SIGN_SS) & multiplier[WORD_SIZE-1];
  assign a_mag = a_neg ? -multiplicand : multiplicand;
  assign b_mag = b_neg ? -multiplier : multiplier;

  // add into upper half when lsb set, then shift right with carry
  assign sum       = {1'b0, prod_q[2*WORD_SIZE-1:WORD_SIZE]} + {1'b0, mcand_q};
  assign prod_next = prod_q[0] ? {sum, prod_q[WORD_SIZE-1:1]}
                               : {1'b0, prod_q[2*WORD_SIZE-1:1]};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= MUL_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        MUL_RUN: begin
          if (count_q == '0) begin
            state_q <= MUL_DONE;
          end else begin
            count_q <= count_q - 1'b1;
          end
        end
        default: begin
          if (start) begin
            state_q <= MUL_RUN;
            count_q <= CNT_W'(WORD_SIZE - 1);
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      mcand_q <= a_mag;
      prod_q  <= {{WORD_SIZE{1'b0}}, b_mag};  // multiplier sits in the low half
      neg_q   <= a_neg ^ b_neg;
    end else if (state_q == MUL_RUN) begin
      prod_q <= (last && neg_q) ? -prod_next : prod_next;
    end
  end

  assign product  = prod_q;
  assign finished = (state_q == MUL_DONE);

endmodule

`default_nettype wire

/* divider/shift_test_restore_divider.sv */
// divisor must be nonzero and signed overflow excluded by the caller; outputs valid while finished
`timescale 1ns/1ps
`default_nettype none

module shift_test_restore_divider (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,
  input  rv32m_pkg::word_t dividend,
  input  rv32m_pkg::word_t divisor,
  input  logic             is_signed,
  output rv32m_pkg::word_t quotient,
  output rv32m_pkg::word_t remainder,
  output logic             finished
);

  import rv32m_pkg::*;

  div_state_e           state_q;
  logic [CNT_W-1:0]     count_q;
  logic                 load;
  logic                 last;
  logic                 dvd_neg, dvs_neg;
  word_t                dvd_mag, dvs_mag;
  word_t                dvs_q;
  word_t                quo_q;   // dividend bits shift out, quotient bits shift in
  word_t                rem_q;
  logic                 q_neg_q;
  logic                 r_neg_q;
  logic [WORD_SIZE:0]   shifted;
  logic [WORD_SIZE+1:0] trial;
  logic                 test_ok;
  word_t                quo_next, rem_next;

  assign load = start && (state_q != DIV_RUN);
  assign last = (state_q == DIV_RUN) && (count_q == '0);

  assign dvd_neg = is_signed & dividend[WORD_SIZE-1];
  assign dvs_neg = is_signed & divisor[WORD_SIZE-1];
  assign dvd_mag = dvd_neg ? -dividend : dividend;
  assign dvs_mag = dvs_neg ? -divisor : divisor;

  // shift in next dividend bit, trial subtract
  assign shifted = {rem_q, quo_q[WORD_SIZE-1]};
  assign trial   = {1'b0, shifted} - {2'b00, dvs_q};
  assign test_ok = ~trial[WORD_SIZE+1];

  // restore on a negative trial
  assign rem_next = test_ok ? trial[WORD_SIZE-1:0] : shifted[WORD_SIZE-1:0];
  assign quo_next = {quo_q[WORD_SIZE-2:0], test_ok};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= DIV_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        DIV_RUN: begin
          if (count_q == '0) begin
            state_q <= DIV_DONE;
          end else begin
            count_q <= count_q - 1'b1;
          end
        end
        default: begin
          if (start) begin
            state_q <= DIV_RUN;
            count_q <= CNT_W'(WORD_SIZE - 1);
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      dvs_q   <= dvs_mag;
      quo_q   <= dvd_mag;
      rem_q   <= '0;
      q_neg_q <= dvd_neg ^ dvs_neg;
      r_neg_q <= dvd_neg;  // remainder follows the dividend
    end else if (last) begin
      quo_q <= q_neg_q ? -quo_next : quo_next;
      rem_q <= r_neg_q ? -rem_next : rem_next;
    end else if (state_q == DIV_RUN) begin
      quo_q <= quo_next;
      rem_q <= rem_next;
    end
  end

  assign quotient  = quo_q;
  assign remainder = rem_q;
  assign finished  = (state_q == DIV_DONE);

endmodule

`default_nettype wire

/* verilog/rv32m_decode.sv */
// accepts a request only when valid and not busy; the caller must hold the request while busy
`timescale 1ns/1ps
`default_nettype none

module rv32m_decode (
  input  logic                      CLK,
  input  logic                      nRST,
  input  rv32m_pkg::m_req_t         req,
  input  logic                      busy,
  output rv32m_pkg::decode_execute_t idex
);

  import rv32m_pkg::*;

  logic            accept;
  logic            start_q;
  decode_execute_t dec;
  decode_execute_t stage_q;

  assign accept = req.valid & ~busy;

  // funct3 to engine flags and operand reading
  always_comb begin
    dec      = '0;
    dec.op_a = req.rs1_data;
    dec.op_b = req.rs2_data;
    unique case (req.op)
      OP_MUL:    begin dec.mul = 1'b1; dec.sign = SIGN_SS; dec.lower_word = 1'b1; end
      OP_MULH:   begin dec.mul = 1'b1; dec.sign = SIGN_SS; end
      OP_MULHSU: begin dec.mul = 1'b1; dec.sign = SIGN_SU; end
      OP_MULHU:  begin dec.mul = 1'b1; dec.sign = SIGN_UU; end
      OP_DIV:    begin dec.div = 1'b1; dec.sign = SIGN_SS; end
      OP_DIVU:   begin dec.div = 1'b1; dec.sign = SIGN_UU; end
      OP_REM:    begin dec.rem = 1'b1; dec.sign = SIGN_SS; end
      OP_REMU:   begin dec.rem = 1'b1; dec.sign = SIGN_UU; end
      default:   dec.sign = SIGN_UU;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      start_q <= 1'b0;
    end else begin
      start_q <= accept;  // single cycle per accepted request
    end
  end

  // operand payload
  always_ff @(posedge CLK) begin
    if (accept) begin
      stage_q <= dec;
    end
  end

  always_comb begin
    idex       = stage_q;
    idex.start = start_q;
  end

endmodule

`default_nettype wire

/* verilog/rv32m_execute.sv */
// busy is combinational from start; results of an identical repeat request come from the held word
`timescale 1ns/1ps
`default_nettype none

module rv32m_execute (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv32m_pkg::decode_execute_t idex,
  output rv32m_pkg::m_rsp_t          rsp
);

  import rv32m_pkg::*;

  // operand saver
  word_t      a_save, b_save;
  sign_mode_e sign_save;
  logic [3:0] kind_save;   // {mul, div, rem, lower_word}
  logic [3:0] kind_curr;
  logic       same_req;
  logic       new_req;

  // special cases and engine control
  logic  div_op;
  logic  div_zero, overflow, special;
  logic  mul_start, div_start;
  logic  mul_finished, div_finished;
  logic  eng_finished;
  logic  active_q;
  logic  done_q;
  logic  busy;
  word_t wdata_q;
  word_t special_result;
  word_t eng_result;

  logic [2*WORD_SIZE-1:0] product;
  word_t quotient, remainder;

  assign kind_curr = {idex.mul, idex.div, idex.rem, idex.lower_word};
  assign same_req  = (kind_curr == kind_save) && (idex.op_a == a_save) &&
                     (idex.op_b == b_save) && (idex.sign == sign_save);
  assign new_req   = idex.start & ~same_req;

  assign div_op   = idex.div | idex.rem;
  assign div_zero = div_op && (idex.op_b == '0);
  assign overflow = div_op && (idex.sign == SIGN_SS) &&
                    (idex.op_a == WORD_MIN) && (idex.op_b == '1);
  assign special  = div_zero | overflow;

  assign mul_start = new_req & idex.mul;
  assign div_start = new_req & div_op & ~special;

  // riscv rules for divide by zero and overflow
  always_comb begin
    if (div_zero) begin
      special_result = idex.div ? '1 : idex.op_a;
    end else begin
      special_result = idex.div ? WORD_MIN : '0;
    end
  end

  // saved kind selects the running engine
  assign eng_finished = kind_save[3] ? mul_finished : div_finished;

  always_comb begin
    if (kind_save[3]) begin
      eng_result = kind_save[0] ? product[WORD_SIZE-1:0] : product[2*WORD_SIZE-1:WORD_SIZE];
    end else begin
      eng_result = kind_save[2] ? quotient : remainder;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      kind_save <= '0;  // matches no real op
    end else if (new_req) begin
      kind_save <= kind_curr;
    end
  end

  always_ff @(posedge CLK) begin
    if (new_req) begin
      a_save    <= idex.op_a;
      b_save    <= idex.op_b;
      sign_save <= idex.sign;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      wdata_q  <= '0;
    end else begin
      done_q <= (idex.start & ~(mul_start | div_start)) | (active_q & eng_finished);
      if (mul_start || div_start) begin
        active_q <= 1'b1;
      end else if (active_q && eng_finished) begin
        active_q <= 1'b0;
      end
      if (new_req && special) begin
        wdata_q <= special_result;
      end else if (active_q && eng_finished) begin
        wdata_q <= eng_result;
      end
    end
  end

  assign busy = idex.start | active_q;
  assign rsp  = '{busy: busy, done: done_q, wdata: wdata_q};

  shift_add_multiplier i_mul (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (mul_start),
    .multiplicand (idex.op_a),
    .multiplier   (idex.op_b),
    .is_signed    (idex.sign),
    .product      (product),
    .finished     (mul_finished)
  );

  shift_test_restore_divider i_div (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (div_start),
    .dividend  (idex.op_a),
    .divisor   (idex.op_b),
    .is_signed (idex.sign == SIGN_SS),
    .quotient  (quotient),
    .remainder (remainder),
    .finished  (div_finished)
  );

endmodule

`default_nettype wire

/* verilog/rv32m_unit.sv */
// requests are taken only while rsp.busy is low; rsp.done pulses once per accepted request
`timescale 1ns/1ps
`default_nettype none

module rv32m_unit (
  input  logic               CLK,
  input  logic               nRST,
  input  rv32m_pkg::m_req_t  req,
  output rv32m_pkg::m_rsp_t  rsp
);

  import rv32m_pkg::*;

  decode_execute_t idex;

  rv32m_decode i_decode (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .busy (rsp.busy),  // back-pressure from execute
    .idex (idex)
  );

  rv32m_execute i_execute (
    .CLK  (CLK),
    .nRST (nRST),
    .idex (idex),
    .rsp  (rsp)
  );

endmodule

`default_nettype wire

/* dv/rv32m_unit_asserts.sv */
// response handshake checks for rv32m_unit, sampled on the rising clock edge
`timescale 1ns/1ps
`default_nettype none

module rv32m_unit_asserts (
  input logic              CLK,
  input logic              nRST,
  input rv32m_pkg::m_rsp_t rsp
);

  // done is a single cycle pulse
  done_pulse: assert property (
    @(posedge CLK) disable iff (!nRST) rsp.done |=> !rsp.done
  ) else $error("rsp.done stayed high for more than one cycle");

  busy_done_excl: assert property (
    @(posedge CLK) disable iff (!nRST) rsp.done |-> !rsp.busy
  ) else $error("rsp.busy was high in a done cycle");

  // both flags quiet while reset is held
  reset_quiet: assert property (
    @(posedge CLK) !nRST |-> (!rsp.busy && !rsp.done)
  ) else $error("rsp.busy or rsp.done high during reset");

endmodule

`default_nettype wire

/* dv/rv32m_unit_tb.sv */
// directed tests for rv32m_unit; results come from a 64-bit reference model, 200-cycle wait bound
`timescale 1ns/1ps
`default_nettype none

module rv32m_unit_tb;

  import rv32m_pkg::*;

  localparam int TIMEOUT = 200;  // cycles per wait

  logic   CLK;
  logic   nRST;
  m_req_t req;
  m_rsp_t rsp;
  integer seed;
  int     errors;
  int     timeouts;

  rv32m_unit i_rv32m_unit (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .rsp  (rsp)
  );

  bind rv32m_unit rv32m_unit_asserts i_rv32m_unit_asserts (
    .CLK  (CLK),
    .nRST (nRST),
    .rsp  (rsp)
  );

  always #20 CLK = ~CLK;

  // RISC-V result from plain 64-bit arithmetic
  function automatic word_t ref_result(input m_op_e op, input word_t a, input word_t b);
    longint      sa;
    longint      sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] prod;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = {32'h0, a};
    ub = {32'h0, b};
    case (op)
      OP_MULHSU: prod = sa * $signed(ub);
      OP_MULHU:  prod = ua * ub;
      default:   prod = sa * sb;
    endcase
    if (op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU} && b == '0) begin
      return (op inside {OP_DIV, OP_DIVU}) ? '1 : a;
    end
    if (op inside {OP_DIV, OP_REM} && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return (op == OP_DIV) ? a : '0;  // signed overflow
    end
    case (op)
      OP_MUL:  return prod[31:0];
      OP_DIV:  return word_t'(sa / sb);  // truncates toward zero
      OP_DIVU: return word_t'(ua / ub);
      OP_REM:  return word_t'(sa % sb);  // sign of the dividend
      OP_REMU: return word_t'(ua % ub);
      default: return prod[63:32];
    endcase
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rsp(input m_rsp_t got, input m_rsp_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s busy/done/wdata %b/%b/%h, expected %b/%b/%h", $time, what,
               got.busy, got.done, got.wdata, exp.busy, exp.done, exp.wdata);
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("FAILED at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  // hold the request until an edge with busy low takes it
  task automatic send_req(input m_op_e op, input word_t a, input word_t b);
    int waited;
    waited = 0;
    req = '{valid: 1'b1, op: op, rs1_data: a, rs2_data: b};
    while (rsp.busy && waited < TIMEOUT) begin
      @(posedge CLK);
      #2;
      waited++;
    end
    if (rsp.busy) begin
      timeouts++;
      $display("timeout: request was never accepted, busy stayed high");
    end
    @(posedge CLK);
    #2;
    req.valid = 1'b0;
  endtask

  task automatic wait_done(output word_t wdata, output int cycles);
    int waited;
    waited = 0;
    while (!rsp.done && waited < TIMEOUT) begin
      @(posedge CLK);
      #2;
      waited++;
    end
    if (!rsp.done) begin
      timeouts++;
      $display("timeout: no done within %0d cycles", TIMEOUT);
    end
    wdata  = rsp.wdata;
    cycles = waited;
  endtask

  task automatic run_op(input m_op_e op, input word_t a, input word_t b);
    word_t got;
    int    cycles;
    send_req(op, a, b);
    wait_done(got, cycles);
    check_word(got, ref_result(op, a, b), $sformatf("%s %h, %h", op.name(), a, b));
  endtask

  // second issue must come from the held result, done one cycle after start
  task automatic repeat_op(input m_op_e op, input word_t a, input word_t b);
    word_t got;
    int    cycles;
    run_op(op, a, b);
    send_req(op, a, b);
    wait_done(got, cycles);
    check_word(got, ref_result(op, a, b), $sformatf("repeat %s %h, %h", op.name(), a, b));
    check_cycles(cycles, 1, $sformatf("repeat %s", op.name()));
  endtask

  task automatic test_reset();
    m_rsp_t exp;
    exp = '0;
    check_rsp(rsp, exp, "response after reset");
  endtask

  // corner pairs, then random pairs; divides keep a nonzero divisor
  task automatic sweep_op(input m_op_e op, input bit nonzero_b);
    word_t corners[4];
    word_t a;
    word_t b;
    corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
    foreach (corners[i]) begin
      foreach (corners[j]) begin
        if (!(nonzero_b && corners[j] == '0)) begin
          run_op(op, corners[i], corners[j]);
        end
      end
    end
    repeat (20) begin
      a = $random(seed);
      b = $random(seed);
      if (nonzero_b) begin
        b = b >> a[4:0];  // spread divisor sizes
        b = (b == '0) ? 32'h1 : b;
      end
      run_op(op, a, b);
    end
  endtask

  task automatic test_special();
    word_t a;
    a = $random(seed);
    run_op(OP_DIV, a, '0);
    run_op(OP_DIVU, a, '0);
    run_op(OP_REM, a, '0);
    run_op(OP_REMU, a, '0);
    run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_op(OP_REM, 32'h8000_0000, 32'hffff_ffff);
  endtask

  task automatic test_repeat();
    word_t a;
    word_t b;
    a = $random(seed);
    b = $random(seed);
    repeat_op(OP_MULHU, a, b);
    repeat_op(OP_REM, a, b | 32'h1);
    repeat_op(OP_DIVU, a, '0);
  endtask

  // second request shows up while the first is running
  task automatic test_backpressure();
    word_t  a;
    word_t  b;
    word_t  got;
    int     cycles;
    m_rsp_t exp;
    a = $random(seed);
    b = $random(seed) | 32'h1;
    send_req(OP_DIVU, a, b);
    req = '{valid: 1'b1, op: OP_MUL, rs1_data: b, rs2_data: a};
    wait_done(got, cycles);
    exp = '{busy: 1'b0, done: 1'b1, wdata: ref_result(OP_DIVU, a, b)};
    check_rsp(rsp, exp, "first result under back-pressure");
    @(posedge CLK);
    #2;
    req.valid = 1'b0;
    exp = '{busy: 1'b1, done: 1'b0, wdata: ref_result(OP_DIVU, a, b)};
    check_rsp(rsp, exp, "held request taken once busy fell");
    wait_done(got, cycles);
    check_word(got, ref_result(OP_MUL, b, a), "held request result");
  endtask

  initial begin
    CLK      = 1'b0;
    nRST     = 1'b0;
    req      = '0;
    seed     = 32'ha46055d3;
    errors   = 0;
    timeouts = 0;
    repeat (8) @(posedge CLK);
    #2;
    nRST = 1'b1;
    test_reset();
    sweep_op(OP_MUL, 1'b0);
    sweep_op(OP_MULH, 1'b0);
    sweep_op(OP_MULHSU, 1'b0);
    sweep_op(OP_MULHU, 1'b0);
    sweep_op(OP_DIV, 1'b1);
    sweep_op(OP_DIVU, 1'b1);
    sweep_op(OP_REM, 1'b1);
    sweep_op(OP_REMU, 1'b1);
    test_special();
    test_repeat();
    test_backpressure();
    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/rv32m_pkg.sv
multiplier/shift_add_multiplier.sv
divider/shift_test_restore_divider.sv
verilog/rv32m_decode.sv
verilog/rv32m_execute.sv
verilog/rv32m_unit.sv
dv/rv32m_unit_asserts.sv
dv/rv32m_unit_tb.sv

/* Makefile */
TOP = rv32m_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
